//--- sources.f
+incdir+include
source/cpstr_pkg.sv
source/cpstr_esc.sv
source/cpstr_emit_arb.sv
source/cpstr_keepalive.sv
source/cpstr_unesc.sv
source/cpstr_link.sv
bench/cpstr_link_tb.sv

//--- bench/cpstr_link_tb.sv
`timescale 1ns/1ps

`include "cpstr_consts.svh"

module cpstr_link_tb;

    localparam logic [7:0] ESC_BYTE     = `CPSTR_ESC_CHAR;
    localparam int N_HOST          = 40;
    localparam int N_RX_ITEMS      = 300;
    localparam int KA_TARGET       = 130;
    localparam int CYCLE_LIMIT     = 20000;
    localparam int HOST_WAIT_LIMIT = 2000;

    logic       clk;
    logic       rst;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic [7:0] line_data;
    logic       line_valid;
    logic       line_ready;
    logic       host_req;
    logic [7:0] host_code;
    logic       host_ack;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_ready;
    logic [7:0] rx_out_data;
    logic       rx_out_valid;
    logic       rx_out_ready;
    logic       cmd_valid;
    logic [7:0] cmd_code;
    logic       ka_valid;
    logic [6:0] ka_seq;

    // model state
    logic [31:0] lfsr_q;
    logic [7:0]  tx_exp[$];
    logic [7:0]  rx_line[$];
    logic [7:0]  rx_exp_data[$];
    logic [7:0]  rx_exp_evt[$];
    int          rx_idx;
    logic        dec_esc;
    logic [6:0]  ka_seq_exp;
    int          ka_count;
    int          host_issued;
    int          host_done;
    int          host_wait;
    logic        tx_acc;
    logic        rx_acc;
    logic        host_acked;
    logic        tx_stop;

    cpstr_link dut (
        .clk              (clk),
        .rst              (rst),
        .i_tx_data        (tx_data),
        .i_tx_valid       (tx_valid),
        .o_tx_ready       (tx_ready),
        .o_line_data      (line_data),
        .o_line_valid     (line_valid),
        .i_line_ready     (line_ready),
        .i_host_emit_req  (host_req),
        .i_host_emit_code (host_code),
        .o_host_emit_ack  (host_ack),
        .i_rx_data        (rx_data),
        .i_rx_valid       (rx_valid),
        .o_rx_ready       (rx_ready),
        .o_rx_out_data    (rx_out_data),
        .o_rx_out_valid   (rx_out_valid),
        .i_rx_out_ready   (rx_out_ready),
        .o_cmd_valid      (cmd_valid),
        .o_cmd_code       (cmd_code),
        .o_ka_valid       (ka_valid),
        .o_ka_seq         (ka_seq)
    );

    always #5 clk = ~clk;

    // ##############################
    // random source
    // ##############################

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // roughly 30% escape bytes
    function automatic logic [7:0] pick_byte();
        logic [31:0] r;
        r = take_bits(7);
        if (r < 38) begin
            return ESC_BYTE;
        end
        r = take_bits(8);
        return r[7:0];
    endfunction

    // command code, flag clear and never the escape byte
    function automatic logic [7:0] pick_cmd();
        logic [31:0] r;
        logic [7:0]  c;
        r = take_bits(7);
        c = {1'b0, r[6:0]};
        if (c == ESC_BYTE) begin
            c = 8'h2B;
        end
        return c;
    endfunction

    // ##############################
    // checking
    // ##############################

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // receive line bytes and the items they should decode to
    task automatic build_rx_stream();
        logic [31:0] kind;
        logic [31:0] r;
        logic [7:0]  b;
        for (int i = 0; i < N_RX_ITEMS; i++) begin
            kind = take_bits(2);
            if (kind == 0) begin
                b = pick_cmd();
                rx_line.push_back(ESC_BYTE);
                rx_line.push_back(b);
                rx_exp_evt.push_back(b);
            end else if (kind == 1) begin
                r = take_bits(7);
                b = {1'b1, r[6:0]};
                rx_line.push_back(ESC_BYTE);
                rx_line.push_back(b);
                rx_exp_evt.push_back(b);
            end else begin
                b = pick_byte();
                if (b == ESC_BYTE) begin
                    rx_line.push_back(ESC_BYTE);
                end
                rx_line.push_back(b);
                rx_exp_data.push_back(b);
            end
        end
    endtask

    // reference decoder for one line transfer
    task automatic decode_line(input logic [7:0] b, output logic is_host);
        logic [7:0] e;
        is_host = 1'b0;
        if (!dec_esc && b == ESC_BYTE) begin
            dec_esc = 1'b1;
        end else if (!dec_esc || b == ESC_BYTE) begin
            // plain byte or second copy of a doubled escape
            dec_esc = 1'b0;
            if (tx_exp.size() == 0) begin
                stop_with_failure("line carried a data byte that was never sent");
            end else begin
                e = tx_exp.pop_front();
                expect_eq("o_line_data", b, e);
            end
        end else if (b[`CPSTR_KA_FLAG_BIT]) begin
            dec_esc = 1'b0;
            expect_eq("o_line_data", b, {1'b1, ka_seq_exp});
            ka_seq_exp = ka_seq_exp + 7'd1;
            ka_count++;
        end else if (!host_req) begin
            stop_with_failure("command code on the line with no host emit pending");
        end else begin
            dec_esc = 1'b0;
            expect_eq("o_line_data", b, host_code);
            is_host = 1'b1;
            host_done++;
        end
    endtask

    task automatic check_rx();
        logic [7:0] e;
        if (rx_out_valid && rx_out_ready) begin
            if (rx_exp_data.size() == 0) begin
                stop_with_failure("receive side produced a data byte that was never sent");
            end else begin
                e = rx_exp_data.pop_front();
                expect_eq("o_rx_out_data", rx_out_data, e);
            end
        end
        if (cmd_valid || ka_valid) begin
            if (rx_exp_evt.size() == 0) begin
                stop_with_failure("receive side produced a control event that was never sent");
            end else begin
                e = rx_exp_evt.pop_front();
                if (e[`CPSTR_KA_FLAG_BIT]) begin
                    expect_eq("o_ka_valid", ka_valid, 1'b1);
                    expect_eq("o_ka_seq", ka_seq, e[6:0]);
                end else begin
                    expect_eq("o_cmd_valid", cmd_valid, 1'b1);
                    expect_eq("o_cmd_code", cmd_code, e);
                end
            end
        end
    endtask

    // sampled ahead of the rising edge, once the driven inputs have settled
    task automatic observe_outputs();
        logic is_host;
        is_host = 1'b0;
        tx_acc = tx_valid & tx_ready;
        rx_acc = rx_valid & rx_ready;
        if (line_valid && line_ready) begin
            decode_line(line_data, is_host);
        end
        // ack belongs to the cycle the host code leaves
        expect_eq("o_host_emit_ack", host_ack, is_host);
        host_acked = is_host;
        if (rx_acc) begin
            rx_idx++;
        end
        check_rx();
        if (host_req) begin
            host_wait++;
        end
        if (host_wait > HOST_WAIT_LIMIT) begin
            stop_with_failure("host emit was not acknowledged in time");
        end
    endtask

    task automatic drive_inputs();
        if (tx_acc) begin
            tx_valid = 1'b0;
        end
        if (host_acked) begin
            host_req = 1'b0;
        end
        if (rx_acc) begin
            rx_valid = 1'b0;
        end
        if (!tx_valid && !tx_stop && take_bits(1) == 1) begin
            tx_data  = pick_byte();
            tx_valid = 1'b1;
            tx_exp.push_back(tx_data);
        end
        if (!host_req && host_issued < N_HOST && take_bits(4) == 0) begin
            host_code = pick_cmd();
            host_req  = 1'b1;
            host_wait = 0;
            host_issued++;
        end
        line_ready = (take_bits(2) != 0);
        if (!rx_valid && rx_idx < rx_line.size() && take_bits(1) == 1) begin
            rx_data  = rx_line[rx_idx];
            rx_valid = 1'b1;
        end
        rx_out_ready = (take_bits(2) != 0);
    endtask

    // ##############################
    // main sequence
    // ##############################

    initial begin : main_seq
        int   cycles;
        logic done;
        clk          = 1'b0;
        rst          = 1'b1;
        tx_data      = '0;
        tx_valid     = 1'b0;
        line_ready   = 1'b0;
        host_req     = 1'b0;
        host_code    = '0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        rx_out_ready = 1'b0;
        lfsr_q       = 32'h519d3c0d;
        rx_idx       = 0;
        dec_esc      = 1'b0;
        ka_seq_exp   = '0;
        ka_count     = 0;
        host_issued  = 0;
        host_done    = 0;
        host_wait    = 0;
        tx_acc       = 1'b0;
        rx_acc       = 1'b0;
        host_acked   = 1'b0;
        tx_stop      = 1'b0;
        build_rx_stream();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // everything idle straight out of reset
        expect_eq("o_line_valid", line_valid, 1'b0);
        expect_eq("o_host_emit_ack", host_ack, 1'b0);
        expect_eq("o_cmd_valid", cmd_valid, 1'b0);
        expect_eq("o_ka_valid", ka_valid, 1'b0);
        expect_eq("o_rx_out_valid", rx_out_valid, 1'b0);
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < CYCLE_LIMIT) begin
            drive_inputs();
            #1;
            observe_outputs();
            @(posedge clk);
            tx_stop = (ka_count >= KA_TARGET);
            done = tx_stop && !tx_valid && tx_exp.size() == 0 && !dec_esc
                && host_done == N_HOST && !host_req
                && !rx_valid && rx_idx == rx_line.size()
                && rx_exp_data.size() == 0 && rx_exp_evt.size() == 0;
            @(negedge clk);
            cycles++;
        end
        if (done) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_with_failure("timed out waiting for the link traffic to drain");
        end
    end

endmodule

//--- source/cpstr_link.sv
`timescale 1ns/1ps

module cpstr_link (
    input  logic       clk,
    input  logic       rst,
    // transmit data stream
    input  logic [7:0] i_tx_data,
    input  logic       i_tx_valid,
    output logic       o_tx_ready,
    // transmit line stream
    output logic [7:0] o_line_data,
    output logic       o_line_valid,
    input  logic       i_line_ready,
    // host emit requests
    input  logic       i_host_emit_req,
    input  logic [7:0] i_host_emit_code,
    output logic       o_host_emit_ack,
    // receive line stream
    input  logic [7:0] i_rx_data,
    input  logic       i_rx_valid,
    output logic       o_rx_ready,
    // receive data out
    output logic [7:0] o_rx_out_data,
    output logic       o_rx_out_valid,
    input  logic       i_rx_out_ready,
    // control events
    output logic       o_cmd_valid,
    output logic [7:0] o_cmd_code,
    output logic       o_ka_valid,
    output logic [6:0] o_ka_seq
);
    import cpstr_pkg::*;

    logic        emit_valid;
    logic [7:0]  emit_code;
    logic        emit_ack;
    logic        ka_req;
    logic        ka_ack;
    cpstr_ctrl_u ka_code;
    cpstr_ctrl_u cmd_code;

    // ##############################
    // transmit path
    // ##############################

    cpstr_keepalive u_keepalive (
        .clk    (clk),
        .rst    (rst),
        .o_req  (ka_req),
        .o_code (ka_code),
        .i_ack  (ka_ack)
    );

    cpstr_emit_arb u_emit_arb (
        .clk          (clk),
        .rst          (rst),
        .i_host_req   (i_host_emit_req),
        .i_host_code  (i_host_emit_code),
        .o_host_ack   (o_host_emit_ack),
        .i_ka_req     (ka_req),
        .i_ka_code    (ka_code),
        .o_ka_ack     (ka_ack),
        .o_emit_valid (emit_valid),
        .o_emit_code  (emit_code),
        .i_emit_ack   (emit_ack)
    );

    cpstr_esc u_esc (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_data       (i_tx_data),
        .i_valid      (i_tx_valid),
        .o_ready      (o_tx_ready),
        .o_data       (o_line_data),
        .o_valid      (o_line_valid),
        .i_ready      (i_line_ready),
        .i_emit_valid (emit_valid),
        .i_emit_data  (emit_code),
        .o_emit_ready (emit_ack)
    );

    // ##############################
    // receive path
    // ##############################

    cpstr_unesc u_unesc (
        .clk         (clk),
        .rst         (rst),
        .i_rx_data   (i_rx_data),
        .i_rx_valid  (i_rx_valid),
        .o_rx_ready  (o_rx_ready),
        .o_data      (o_rx_out_data),
        .o_valid     (o_rx_out_valid),
        .i_ready     (i_rx_out_ready),
        .o_cmd_valid (o_cmd_valid),
        .o_cmd_code  (cmd_code),
        .o_ka_valid  (o_ka_valid),
        .o_ka_seq    (o_ka_seq)
    );

    assign o_cmd_code = cmd_code;

endmodule

//--- source/cpstr_unesc.sv
`timescale 1ns/1ps

`include "cpstr_consts.svh"

module cpstr_unesc (
    input  logic                  clk,
    input  logic                  rst,
    // line stream in
    input  logic [7:0]            i_rx_data,
    input  logic                  i_rx_valid,
    output logic                  o_rx_ready,
    // data stream out
    output logic [7:0]            o_data,
    output logic                  o_valid,
    input  logic                  i_ready,
    // control events
    output logic                  o_cmd_valid,
    output cpstr_pkg::cpstr_ctrl_u o_cmd_code,
    output logic                  o_ka_valid,
    output logic [6:0]            o_ka_seq
);
    import cpstr_pkg::*;

    cpstr_unesc_state_e state_q;
    cpstr_ctrl_u        rx_code;
    logic               rx_is_esc;
    logic               ctrl_take;
    logic               cmd_valid_q;
    logic               ka_valid_q;

    assign rx_code   = i_rx_data;
    assign rx_is_esc = (i_rx_data == `CPSTR_ESC_CHAR);
    assign o_data    = i_rx_data;

    // ##############################
    // escape stripping
    // ##############################

    always_comb begin
        o_valid    = 1'b0;
        o_rx_ready = 1'b1;
        ctrl_take  = 1'b0;
        if (state_q == unesc_data) begin
            if (!rx_is_esc) begin
                o_valid    = i_rx_valid;
                o_rx_ready = i_ready;
            end
        end else if (rx_is_esc) begin
            // doubled escape is one data byte
            o_valid    = i_rx_valid;
            o_rx_ready = i_ready;
        end else begin
            ctrl_take = i_rx_valid;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= unesc_data;
        end else if (state_q == unesc_data) begin
            if (i_rx_valid && rx_is_esc) begin
                state_q <= unesc_escaped;
            end
        end else if (i_rx_valid && o_rx_ready) begin
            state_q <= unesc_data;
        end
    end

    // ##############################
    // control events
    // ##############################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid_q <= 1'b0;
            ka_valid_q  <= 1'b0;
        end else begin
            cmd_valid_q <= ctrl_take & ~rx_code[`CPSTR_KA_FLAG_BIT];
            ka_valid_q  <= ctrl_take & rx_code[`CPSTR_KA_FLAG_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_take) begin
            o_cmd_code.cmd.flag   <= 1'b0;
            o_cmd_code.cmd.opcode <= rx_code.cmd.opcode;
            o_cmd_code.cmd.arg    <= rx_code.cmd.arg;
            o_ka_seq              <= rx_code.ka.seq;
        end
    end

    assign o_cmd_valid = cmd_valid_q;
    assign o_ka_valid  = ka_valid_q;

    // one line byte yields at most one kind of event
    a_one_event: assert property (
        @(posedge clk) disable iff (rst)
        !(o_cmd_valid && o_ka_valid)
    );

endmodule

//--- source/cpstr_keepalive.sv
`timescale 1ns/1ps

`include "cpstr_consts.svh"

module cpstr_keepalive (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  o_req,
    output cpstr_pkg::cpstr_ctrl_u o_code,
    input  logic                  i_ack
);
    import cpstr_pkg::*;

    logic [15:0] cnt_q;
    logic [6:0]  seq_q;
    logic        req_q;

    // ##############################
    // period counter
    // ##############################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
            req_q <= 1'b0;
            seq_q <= '0;
        end else if (req_q) begin
            if (i_ack) begin
                // restart the period, sequence wraps at 128
                req_q <= 1'b0;
                cnt_q <= '0;
                seq_q <= seq_q + 7'd1;
            end
        end else if (cnt_q == `CPSTR_KA_PERIOD - 16'd1) begin
            req_q <= 1'b1;
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 16'd1;
        end
    end

    assign o_req = req_q;

    // code is built through the keepalive view
    always_comb begin
        o_code.ka.flag = 1'b1;
        o_code.ka.seq  = seq_q;
    end

endmodule

//--- source/cpstr_emit_arb.sv
`timescale 1ns/1ps

module cpstr_emit_arb (
    input  logic       clk,
    input  logic       rst,
    // host peer
    input  logic       i_host_req,
    input  logic [7:0] i_host_code,
    output logic       o_host_ack,
    // keepalive peer
    input  logic       i_ka_req,
    input  logic [7:0] i_ka_code,
    output logic       o_ka_ack,
    // escaper emit port
    output logic       o_emit_valid,
    output logic [7:0] o_emit_code,
    input  logic       i_emit_ack
);

    logic grant_valid_q;
    logic grant_host_q;
    logic last_host_q;
    logic pick_host;

    // on a tie the peer not served last wins
    assign pick_host = i_host_req & (~i_ka_req | ~last_host_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant_valid_q <= 1'b0;
            grant_host_q  <= 1'b0;
            last_host_q   <= 1'b0;
        end else if (grant_valid_q) begin
            if (i_emit_ack) begin
                grant_valid_q <= 1'b0;
                last_host_q   <= grant_host_q;
            end
        end else if (i_host_req || i_ka_req) begin
            grant_valid_q <= 1'b1;
            grant_host_q  <= pick_host;
        end
    end

    // ##############################
    // emit mux and ack routing
    // ##############################

    assign o_emit_valid = grant_valid_q;
    assign o_emit_code  = grant_host_q ? i_host_code : i_ka_code;

    assign o_host_ack = i_emit_ack & grant_valid_q & grant_host_q;
    assign o_ka_ack   = i_emit_ack & grant_valid_q & ~grant_host_q;

    // owner and its code are fixed from grant until the code has gone out
    a_grant_held: assert property (
        @(posedge clk) disable iff (rst)
        grant_valid_q && !i_emit_ack |=>
            grant_valid_q && $stable(grant_host_q) && $stable(o_emit_code)
    );

endmodule

//--- source/cpstr_esc.sv
`timescale 1ns/1ps

`include "cpstr_consts.svh"

module cpstr_esc (
    input  logic       i_clk,
    input  logic       i_rst,
    // data stream in
    input  logic [7:0] i_data,
    input  logic       i_valid,
    output logic       o_ready,
    // line stream out
    output logic [7:0] o_data,
    output logic       o_valid,
    input  logic       i_ready,
    // emit port
    input  logic       i_emit_valid,
    input  logic [7:0] i_emit_data,
    output logic       o_emit_ready
);
    import cpstr_pkg::*;

    cpstr_esc_state_e state_q;
    cpstr_esc_state_e state_d;
    logic             sent;
    logic             in_is_esc;

    // a line byte leaves this cycle
    assign sent = o_valid & i_ready;
    assign in_is_esc = (i_data == `CPSTR_ESC_CHAR);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= esc_pass;
        end else begin
            state_q <= state_d;
        end
    end

    // ##############################
    // next state
    // ##############################

    always_comb begin
        state_d = state_q;
        case (state_q)
            esc_pass: begin
                if (i_valid) begin
                    // state only moves once the presented byte is gone
                    if (sent && in_is_esc) begin
                        state_d = esc_dup;
                    end else if (sent && i_emit_valid) begin
                        state_d = esc_emit_esc;
                    end
                end else if (i_emit_valid) begin
                    state_d = esc_emit_esc;
                end
            end
            esc_dup: begin
                if (sent) begin
                    // pending emit first, so a run of escape bytes cannot starve it
                    if (i_emit_valid) begin
                        state_d = esc_emit_esc;
                    end else begin
                        state_d = esc_pass;
                    end
                end
            end
            esc_emit_esc: begin
                if (sent) begin
                    state_d = esc_emit_code;
                end
            end
            esc_emit_code: begin
                if (sent) begin
                    state_d = esc_pass;
                end
            end
            default: begin
                state_d = esc_pass;
            end
        endcase
    end

    // ##############################
    // line side and handshakes
    // ##############################

    always_comb begin
        o_data  = `CPSTR_ESC_CHAR;
        o_valid = 1'b1;
        o_ready = 1'b0;
        case (state_q)
            esc_pass: begin
                o_data  = i_data;
                o_valid = i_valid;
                // an escape byte is only taken on its second copy
                o_ready = i_ready & ~in_is_esc;
            end
            esc_dup: begin
                o_ready = i_ready;
            end
            esc_emit_code: begin
                o_data = i_emit_data;
            end
            default: begin
                o_ready = 1'b0;
            end
        endcase
    end

    assign o_emit_ready = (state_q == esc_emit_code) & sent;

    // held byte stays put while the line stalls, upstream and arbiter included
    a_line_stable: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_valid && !i_ready |=> o_valid && $stable(o_data)
    );

endmodule

//--- source/cpstr_pkg.sv
package cpstr_pkg;

    // ##############################
    // control code layouts
    // ##############################

    // keepalive view, flag set
    typedef struct packed {
        logic       flag;
        logic [6:0] seq;
    } cpstr_ka_view_t;

    // command view, flag clear
    typedef struct packed {
        logic       flag;
        logic [2:0] opcode;
        logic [3:0] arg;
    } cpstr_cmd_view_t;

    typedef union packed {
        cpstr_ka_view_t  ka;
        cpstr_cmd_view_t cmd;
    } cpstr_ctrl_u;

    // ##############################
    // FSM states
    // ##############################

    typedef enum logic [1:0] {
        esc_pass      = 2'd0,
        esc_dup       = 2'd1,
        esc_emit_esc  = 2'd2,
        esc_emit_code = 2'd3
    } cpstr_esc_state_e;

    typedef enum logic {
        unesc_data    = 1'b0,
        unesc_escaped = 1'b1
    } cpstr_unesc_state_e;

endpackage

//--- include/cpstr_consts.svh
`ifndef CPSTR_CONSTS_SVH
`define CPSTR_CONSTS_SVH

// escape byte shared by the transmit and receive paths
`define CPSTR_ESC_CHAR 8'h1B

// clock cycles between keepalive requests, held in a 16-bit counter
`define CPSTR_KA_PERIOD 16'd64

// bit index that marks a keepalive code on the line
`define CPSTR_KA_FLAG_BIT 7

`endif
